// File: common/acq_pkg.sv
package acq_pkg;

    // ------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------

    // Sensing channels behind the analog mux
    localparam int NUM_CHAN   = 8;
    // ADC conversion result
    localparam int RESULT_W   = 16;
    // Channel tag stored with every FIFO word
    localparam int CHAN_IDX_W = 3;

    // Result FIFO geometry
    localparam int FIFO_DEPTH = 8;
    // Fill count must reach FIFO_DEPTH itself, so one bit wider than the pointer
    localparam int FIFO_CNT_W = 4;
    localparam int FIFO_PTR_W = 3;

    // ------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------

    localparam int REG_ADDR_W = 6;
    localparam int REG_DATA_W = 8;

    // AFE control, temperature monitor enable lives here
    localparam logic [REG_ADDR_W-1:0] ADDR_AFE_CTRL = 6'h13;
    // Channel enable mask, one bit per channel
    localparam logic [REG_ADDR_W-1:0] ADDR_CHEN     = 6'h16;
    // Acquisition control, watermark and sampling enable
    localparam logic [REG_ADDR_W-1:0] ADDR_ACQ_CTRL = 6'h23;

    // Field positions inside the control registers
    localparam int AFE_ENMON_BIT = 3;
    localparam int ACQ_WM_LSB    = 2;
    localparam int ACQ_SAMP_BIT  = 7;

    // ------------------------------------------------------------
    // Temperature monitor FSM
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        TEMP_IDLE,
        TEMP_RUN,
        TEMP_HOLD
    } temp_state_e;

endpackage

// File: hdl/acq_config_regs.sv
`timescale 1ns/10ps

module acq_config_regs (
    input  logic                            SAMPLE_CLK,
    input  logic                            nrst_sync,
    input  logic                            reg_wr,
    input  logic [acq_pkg::REG_ADDR_W-1:0]  reg_addr,
    input  logic [acq_pkg::REG_DATA_W-1:0]  reg_wdata,
    output logic [acq_pkg::NUM_CHAN-1:0]    chen,
    output logic                            ensamp_active,
    output logic [acq_pkg::FIFO_CNT_W-1:0]  watermark,
    output logic                            enmontsense
);

    // Raw sampling enable bit, before the channel mask test
    logic ensamp;

    // Address decode, one strobe per register
    logic wr_afe_ctrl;
    logic wr_chen;
    logic wr_acq_ctrl;

    assign wr_afe_ctrl = reg_wr && (reg_addr == acq_pkg::ADDR_AFE_CTRL);
    assign wr_chen     = reg_wr && (reg_addr == acq_pkg::ADDR_CHEN);
    assign wr_acq_ctrl = reg_wr && (reg_addr == acq_pkg::ADDR_ACQ_CTRL);

    // ------------------------------------------------------------
    // Register fields
    // ------------------------------------------------------------

    // Unlisted addresses fall through and leave every field alone
    always_ff @(posedge SAMPLE_CLK or negedge nrst_sync) begin
        if (!nrst_sync) begin
            chen        <= '0;
            ensamp      <= 1'b0;
            watermark   <= '0;
            enmontsense <= 1'b0;
        end else begin
            if (wr_afe_ctrl) begin
                enmontsense <= reg_wdata[acq_pkg::AFE_ENMON_BIT];
            end
            if (wr_chen) begin
                chen <= reg_wdata[acq_pkg::NUM_CHAN-1:0];
            end
            if (wr_acq_ctrl) begin
                ensamp    <= reg_wdata[acq_pkg::ACQ_SAMP_BIT];
                watermark <= reg_wdata[acq_pkg::ACQ_WM_LSB +: acq_pkg::FIFO_CNT_W];
            end
        end
    end

    // Sampling only counts when some channel is enabled
    // Downstream blocks use this level and never the raw bit
    assign ensamp_active = ensamp && (|chen);

endmodule

// File: hdl/channel_sequencer.sv
`timescale 1ns/10ps

module channel_sequencer (
    input  logic                            SAMPLE_CLK,
    input  logic                            nrst_sync,
    input  logic                            done,
    input  logic                            narst,
    input  logic                            ensamp_active,
    input  logic [acq_pkg::NUM_CHAN-1:0]    chen,
    output logic [acq_pkg::NUM_CHAN-1:0]    atmchsel,
    output logic                            done_qual,
    output logic [acq_pkg::CHAN_IDX_W-1:0]  data_chan,
    output logic                            last_word
);

    logic                            discard_first;
    logic                            ensamp_q;
    logic [acq_pkg::NUM_CHAN-1:0]    chen_q;
    logic                            reload;
    logic [acq_pkg::CHAN_IDX_W-1:0]  chan_q;
    logic [acq_pkg::CHAN_IDX_W-1:0]  sel_chan;
    logic [acq_pkg::CHAN_IDX_W-1:0]  low_chan;
    logic [acq_pkg::CHAN_IDX_W-1:0]  high_chan;
    logic [acq_pkg::CHAN_IDX_W-1:0]  next_chan;

    // Lowest set bit of the mask
    function automatic logic [acq_pkg::CHAN_IDX_W-1:0] lowest_en(
        input logic [acq_pkg::NUM_CHAN-1:0] mask
    );
        logic [acq_pkg::CHAN_IDX_W-1:0] idx;
        idx = '0;
        for (int i = acq_pkg::NUM_CHAN - 1; i >= 0; i--) begin
            if (mask[i]) idx = acq_pkg::CHAN_IDX_W'(i);
        end
        return idx;
    endfunction

    // Highest set bit of the mask
    function automatic logic [acq_pkg::CHAN_IDX_W-1:0] highest_en(
        input logic [acq_pkg::NUM_CHAN-1:0] mask
    );
        logic [acq_pkg::CHAN_IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < acq_pkg::NUM_CHAN; i++) begin
            if (mask[i]) idx = acq_pkg::CHAN_IDX_W'(i);
        end
        return idx;
    endfunction

    // Next enabled channel above cur, wrapping round to the bottom
    function automatic logic [acq_pkg::CHAN_IDX_W-1:0] next_en(
        input logic [acq_pkg::NUM_CHAN-1:0]   mask,
        input logic [acq_pkg::CHAN_IDX_W-1:0] cur
    );
        logic [acq_pkg::CHAN_IDX_W-1:0] idx;
        int                             j;
        idx = cur;
        // Walk the offsets downward so the nearest hit is kept
        for (int k = acq_pkg::NUM_CHAN; k >= 1; k--) begin
            j = (int'(cur) + k) % acq_pkg::NUM_CHAN;
            if (mask[j]) idx = acq_pkg::CHAN_IDX_W'(j);
        end
        return idx;
    endfunction

    // ------------------------------------------------------------
    // DONE qualification
    // ------------------------------------------------------------

    // Re-armed whenever the ADC is held off
    always_ff @(posedge SAMPLE_CLK or negedge nrst_sync) begin
        if (!nrst_sync) begin
            discard_first <= 1'b1;
        end else if (!narst) begin
            discard_first <= 1'b1;
        end else if (discard_first && done) begin
            discard_first <= 1'b0;
        end
    end

    // Startup DONE swallowed, later ones pass with no delay
    assign done_qual = done && !discard_first;

    // ------------------------------------------------------------
    // Round-robin channel select
    // ------------------------------------------------------------

    always_ff @(posedge SAMPLE_CLK or negedge nrst_sync) begin
        if (!nrst_sync) begin
            ensamp_q <= 1'b0;
            chen_q   <= '0;
            chan_q   <= '0;
        end else begin
            ensamp_q <= ensamp_active;
            chen_q   <= chen;
            // Step only on conversions that belong to the sampling stream
            if (done_qual && ensamp_active) chan_q <= next_chan;
            else chan_q <= sel_chan;
        end
    end

    // Start of sampling or a new mask restarts from the bottom
    assign reload    = (ensamp_active && !ensamp_q) || (chen != chen_q);
    assign low_chan  = lowest_en(chen);
    assign high_chan = highest_en(chen);
    assign sel_chan  = reload ? low_chan : chan_q;
    assign next_chan = next_en(chen, sel_chan);

    assign data_chan = sel_chan;
    assign atmchsel  = ensamp_active ? (acq_pkg::NUM_CHAN'(1) << sel_chan) : '0;
    assign last_word = ensamp_active && (sel_chan == high_chan);

endmodule

// File: sample_fifo/sample_fifo.sv
`timescale 1ns/10ps

module sample_fifo (
    input  logic                            SAMPLE_CLK,
    input  logic                            nrst_sync,
    input  logic [acq_pkg::RESULT_W-1:0]    result,
    input  logic                            done_qual,
    input  logic [acq_pkg::CHAN_IDX_W-1:0]  data_chan,
    input  logic                            ensamp_active,
    input  logic                            temp_run,
    input  logic [acq_pkg::FIFO_CNT_W-1:0]  watermark,
    input  logic                            fifo_pop,
    output logic [acq_pkg::RESULT_W-1:0]    fifo_rd_data,
    output logic [acq_pkg::CHAN_IDX_W-1:0]  fifo_rd_chan,
    output logic                            data_rdy,
    output logic                            fifo_overflow,
    output logic                            fifo_underflow,
    output logic                            irq
);

    // Tagged storage, result and channel side by side
    logic [acq_pkg::RESULT_W-1:0]    mem_data [acq_pkg::FIFO_DEPTH];
    logic [acq_pkg::CHAN_IDX_W-1:0]  mem_chan [acq_pkg::FIFO_DEPTH];

    logic [acq_pkg::FIFO_PTR_W-1:0]  wr_ptr;
    logic [acq_pkg::FIFO_PTR_W-1:0]  rd_ptr;
    logic [acq_pkg::FIFO_CNT_W-1:0]  count;

    logic full;
    logic empty;
    logic wr_req;
    logic wr_ok;
    logic pop_ok;
    logic ensamp_q;
    logic samp_stop;

    assign full  = (count == acq_pkg::FIFO_CNT_W'(acq_pkg::FIFO_DEPTH));
    assign empty = (count == '0);

    // Temperature conversions never land in the sample stream
    assign wr_req = done_qual && ensamp_active && !temp_run;
    assign pop_ok = fifo_pop && !empty;
    // A pop in the same cycle frees the slot for a full FIFO
    assign wr_ok  = wr_req && (!full || pop_ok);

    // ------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------

    always_ff @(posedge SAMPLE_CLK) begin
        if (wr_ok) begin
            mem_data[wr_ptr] <= result;
            mem_chan[wr_ptr] <= data_chan;
        end
    end

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge SAMPLE_CLK or negedge nrst_sync) begin
        if (!nrst_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head word, visible without a read cycle
    assign fifo_rd_data = mem_data[rd_ptr];
    assign fifo_rd_chan = mem_chan[rd_ptr];

    assign data_rdy = !empty && (count >= watermark);

    // ------------------------------------------------------------
    // Sticky error flags
    // ------------------------------------------------------------

    assign samp_stop = ensamp_q && !ensamp_active;

    always_ff @(posedge SAMPLE_CLK or negedge nrst_sync) begin
        if (!nrst_sync) begin
            ensamp_q       <= 1'b0;
            fifo_overflow  <= 1'b0;
            fifo_underflow <= 1'b0;
        end else begin
            ensamp_q <= ensamp_active;
            // End of sampling wins over a new error on the same edge
            if (samp_stop) begin
                fifo_overflow  <= 1'b0;
                fifo_underflow <= 1'b0;
            end else begin
                // Dropped word
                if (wr_req && !wr_ok) fifo_overflow <= 1'b1;
                if (fifo_pop && empty) fifo_underflow <= 1'b1;
            end
        end
    end

    assign irq = fifo_overflow || fifo_underflow;

endmodule

// File: hdl/temp_monitor.sv
`timescale 1ns/10ps

module temp_monitor (
    input  logic                          SAMPLE_CLK,
    input  logic                          nrst_sync,
    input  logic                          enmontsense,
    input  logic                          done_qual,
    input  logic [acq_pkg::RESULT_W-1:0]  result,
    output logic                          temp_run,
    output logic [acq_pkg::RESULT_W-1:0]  tempval,
    output logic                          temp_valid
);

    acq_pkg::temp_state_e state;
    acq_pkg::temp_state_e state_nxt;

    logic enmon_q;
    logic enmon_rise;

    // Request is the enable edge, a held level asks only once
    assign enmon_rise = enmontsense && !enmon_q;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            acq_pkg::TEMP_IDLE: begin
                if (enmon_rise) state_nxt = acq_pkg::TEMP_RUN;
            end
            acq_pkg::TEMP_RUN: begin
                // Abort beats capture
                if (!enmontsense) state_nxt = acq_pkg::TEMP_IDLE;
                else if (done_qual) state_nxt = acq_pkg::TEMP_HOLD;
            end
            acq_pkg::TEMP_HOLD: begin
                if (!enmontsense) state_nxt = acq_pkg::TEMP_IDLE;
            end
            default: state_nxt = acq_pkg::TEMP_IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // State, capture and valid flag
    // ------------------------------------------------------------

    always_ff @(posedge SAMPLE_CLK or negedge nrst_sync) begin
        if (!nrst_sync) begin
            state      <= acq_pkg::TEMP_IDLE;
            enmon_q    <= 1'b0;
            tempval    <= '0;
            temp_valid <= 1'b0;
        end else begin
            state   <= state_nxt;
            enmon_q <= enmontsense;
            // Old value stays valid until a fresh run begins
            if (state == acq_pkg::TEMP_IDLE && enmon_rise) temp_valid <= 1'b0;
            // One result per request
            if (state == acq_pkg::TEMP_RUN && enmontsense && done_qual) begin
                tempval    <= result;
                temp_valid <= 1'b1;
            end
        end
    end

    // Keeps the ADC running for the one-shot
    assign temp_run = (state == acq_pkg::TEMP_RUN);

endmodule

// File: hdl/acq_top.sv
`timescale 1ns/10ps

module acq_top (
    input  logic                            SAMPLE_CLK,
    input  logic                            nrst_sync,
    // Register write port
    input  logic                            reg_wr,
    input  logic [acq_pkg::REG_ADDR_W-1:0]  reg_addr,
    input  logic [acq_pkg::REG_DATA_W-1:0]  reg_wdata,
    // ADC side
    input  logic [acq_pkg::RESULT_W-1:0]    result,
    input  logic                            done,
    // FIFO readout
    input  logic                            fifo_pop,
    output logic                            narst,
    output logic [acq_pkg::NUM_CHAN-1:0]    atmchsel,
    output logic                            last_word,
    output logic [acq_pkg::RESULT_W-1:0]    fifo_rd_data,
    output logic [acq_pkg::CHAN_IDX_W-1:0]  fifo_rd_chan,
    output logic                            data_rdy,
    output logic                            fifo_overflow,
    output logic                            fifo_underflow,
    output logic                            irq,
    // Temperature result
    output logic [acq_pkg::RESULT_W-1:0]    tempval,
    output logic                            temp_valid
);

    // Config outputs
    logic [acq_pkg::NUM_CHAN-1:0]    chen;
    logic                            ensamp_active;
    logic [acq_pkg::FIFO_CNT_W-1:0]  watermark;
    logic                            enmontsense;

    // Sequencer outputs
    logic                            done_qual;
    logic [acq_pkg::CHAN_IDX_W-1:0]  data_chan;

    // Temperature one-shot in progress
    logic                            temp_run;

    // ------------------------------------------------------------
    // Configuration and sequencing
    // ------------------------------------------------------------

    acq_config_regs u_cfg (
        .SAMPLE_CLK    (SAMPLE_CLK),
        .nrst_sync     (nrst_sync),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .chen          (chen),
        .ensamp_active (ensamp_active),
        .watermark     (watermark),
        .enmontsense   (enmontsense)
    );

    channel_sequencer u_seq (
        .SAMPLE_CLK    (SAMPLE_CLK),
        .nrst_sync     (nrst_sync),
        .done          (done),
        .narst         (narst),
        .ensamp_active (ensamp_active),
        .chen          (chen),
        .atmchsel      (atmchsel),
        .done_qual     (done_qual),
        .data_chan     (data_chan),
        .last_word     (last_word)
    );

    // ------------------------------------------------------------
    // Result paths
    // ------------------------------------------------------------

    sample_fifo u_fifo (
        .SAMPLE_CLK     (SAMPLE_CLK),
        .nrst_sync      (nrst_sync),
        .result         (result),
        .done_qual      (done_qual),
        .data_chan      (data_chan),
        .ensamp_active  (ensamp_active),
        .temp_run       (temp_run),
        .watermark      (watermark),
        .fifo_pop       (fifo_pop),
        .fifo_rd_data   (fifo_rd_data),
        .fifo_rd_chan   (fifo_rd_chan),
        .data_rdy       (data_rdy),
        .fifo_overflow  (fifo_overflow),
        .fifo_underflow (fifo_underflow),
        .irq            (irq)
    );

    temp_monitor u_temp (
        .SAMPLE_CLK  (SAMPLE_CLK),
        .nrst_sync   (nrst_sync),
        .enmontsense (enmontsense),
        .done_qual   (done_qual),
        .result      (result),
        .temp_run    (temp_run),
        .tempval     (tempval),
        .temp_valid  (temp_valid)
    );

    // ADC runs for the sample stream or a temperature one-shot
    assign narst = ensamp_active || temp_run;

endmodule

// File: tests/acq_top_sva.sv
`timescale 1ns/10ps

module acq_top_sva (
    input logic                          SAMPLE_CLK,
    input logic                          nrst_sync,
    input logic                          narst,
    input logic [acq_pkg::NUM_CHAN-1:0]  atmchsel,
    input logic                          irq,
    input logic                          fifo_overflow,
    input logic                          fifo_underflow
);

    // Read back by the testbench at the end of the run
    int fail_count = 0;

    // ------------------------------------------------------------
    // Mux select
    // ------------------------------------------------------------

    // Never two channels on the ADC input at once
    a_sel_onehot: assert property (@(posedge SAMPLE_CLK) disable iff (!nrst_sync)
        $onehot0(atmchsel))
        else begin
            fail_count++;
            $error("atmchsel selects more than one channel");
        end

    // Mux parked while the ADC is held in reset
    a_sel_parked: assert property (@(posedge SAMPLE_CLK) disable iff (!nrst_sync)
        !narst |-> (atmchsel == '0))
        else begin
            fail_count++;
            $error("atmchsel is nonzero while narst is low");
        end

    // ------------------------------------------------------------
    // Interrupt source
    // ------------------------------------------------------------

    a_irq_source: assert property (@(posedge SAMPLE_CLK) disable iff (!nrst_sync)
        irq |-> (fifo_overflow || fifo_underflow))
        else begin
            fail_count++;
            $error("irq is high with neither FIFO error flag set");
        end

endmodule

bind acq_top acq_top_sva sva0 (
    .SAMPLE_CLK     (SAMPLE_CLK),
    .nrst_sync      (nrst_sync),
    .narst          (narst),
    .atmchsel       (atmchsel),
    .irq            (irq),
    .fifo_overflow  (fifo_overflow),
    .fifo_underflow (fifo_underflow)
);

// File: tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic SAMPLE_CLK,
    output logic nrst_sync
);

    // 8 ns period
    initial begin
        SAMPLE_CLK = 1'b0;
        forever #4 SAMPLE_CLK = ~SAMPLE_CLK;
    end

    // Reset held over three rising edges
    // Released on a falling edge, clear of the active edge
    initial begin
        nrst_sync = 1'b0;
        repeat (3) @(posedge SAMPLE_CLK);
        @(negedge SAMPLE_CLK);
        nrst_sync = 1'b1;
    end

endmodule

// File: tests/acq_top_tb.sv
`timescale 1ns/10ps

module acq_top_tb;

    typedef enum {STEP_WRITE, STEP_DONE, STEP_POP, STEP_IDLE} step_kind_e;

    // One table row, -1 in an expected field means don't care
    typedef struct {
        step_kind_e kind;
        int         addr;
        int         data;
        int         chan;
        int         exp_narst;
        int         exp_sel;
        int         exp_rdy;
        int         exp_irq;
        int         exp_flags;
        int         exp_last;
        int         exp_tv;
    } step_t;

    logic                            SAMPLE_CLK;
    logic                            nrst_sync;
    logic                            reg_wr;
    logic [acq_pkg::REG_ADDR_W-1:0]  reg_addr;
    logic [acq_pkg::REG_DATA_W-1:0]  reg_wdata;
    logic [acq_pkg::RESULT_W-1:0]    result;
    logic                            done;
    logic                            fifo_pop;
    logic                            narst;
    logic [acq_pkg::NUM_CHAN-1:0]    atmchsel;
    logic                            last_word;
    logic [acq_pkg::RESULT_W-1:0]    fifo_rd_data;
    logic [acq_pkg::CHAN_IDX_W-1:0]  fifo_rd_chan;
    logic                            data_rdy;
    logic                            fifo_overflow;
    logic                            fifo_underflow;
    logic                            irq;
    logic [acq_pkg::RESULT_W-1:0]    tempval;
    logic                            temp_valid;

    step_t                          steps[$];
    // FIFO reference model, tagged words in write order
    logic [acq_pkg::RESULT_W-1:0]   model_data[$];
    logic [acq_pkg::CHAN_IDX_W-1:0] model_chan[$];
    logic [acq_pkg::RESULT_W-1:0]   last_result;
    integer                         seed = 32'hb7d0;
    int                             row_idx;
    int                             checks;
    int                             errors;
    int                             cycles;

    tb_clock_gen clk0 (.SAMPLE_CLK(SAMPLE_CLK), .nrst_sync(nrst_sync));

    acq_top dut0 (.*);

    task automatic add_step(input step_kind_e kind, input int addr, input int data,
                            input int chan, input int narst_e, input int sel_e,
                            input int rdy_e, input int irq_e, input int flags_e,
                            input int last_e, input int tv_e);
        step_t s;
        s = '{kind, addr, data, chan, narst_e, sel_e, rdy_e, irq_e, flags_e, last_e, tv_e};
        steps.push_back(s);
    endtask

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------

    // kind, addr, data, stored chan, narst, atmchsel, data_rdy, irq,
    // {overflow, underflow}, last_word, temp_valid
    task automatic build_table();
        // Channel mask and sampling enable
        add_step(STEP_WRITE, acq_pkg::ADDR_CHEN, 'h52, -1, 0, 'h00, 0, 0, 0, 0, 0);
        add_step(STEP_WRITE, acq_pkg::ADDR_ACQ_CTRL, 'h0c, -1, 0, 'h00, 0, 0, 0, 0, -1);
        add_step(STEP_WRITE, acq_pkg::ADDR_ACQ_CTRL, 'h8c, -1, 1, 'h02, 0, 0, 0, 0, -1);
        add_step(STEP_WRITE, acq_pkg::ADDR_CHEN, 'h00, -1, 0, 'h00, 0, 0, 0, 0, -1);
        add_step(STEP_WRITE, acq_pkg::ADDR_CHEN, 'h52, -1, 1, 'h02, 0, 0, 0, 0, -1);
        // Startup DONE dropped, then channels 1, 4, 6 with watermark 3
        add_step(STEP_DONE, 0, 0, -1, 1, 'h02, 0, 0, 0, 0, -1);
        add_step(STEP_DONE, 0, 0, 1, 1, 'h10, 0, 0, 0, 0, -1);
        add_step(STEP_DONE, 0, 0, 4, 1, 'h40, 0, 0, 0, 1, -1);
        add_step(STEP_DONE, 0, 0, 6, 1, 'h02, 1, 0, 0, 0, -1);
        add_step(STEP_POP, 0, 0, -1, 1, 'h02, 0, 0, 0, 0, -1);
        add_step(STEP_POP, 0, 0, -1, 1, 'h02, 0, 0, 0, 0, -1);
        add_step(STEP_POP, 0, 0, -1, 1, 'h02, 0, 0, 0, 0, -1);
        // Nine writes into eight words, the ninth is lost
        for (int i = 0; i < 9; i++) begin
            add_step(STEP_DONE, 0, 0, (i % 3 == 0) ? 1 : ((i % 3 == 1) ? 4 : 6), 1,
                     (i % 3 == 0) ? 'h10 : ((i % 3 == 1) ? 'h40 : 'h02),
                     (i >= 2) ? 1 : 0, (i == 8) ? 1 : 0, (i == 8) ? 2 : 0,
                     (i % 3 == 1) ? 1 : 0, -1);
        end
        // Drain, then one pop too many
        for (int i = 7; i >= 0; i--) begin
            add_step(STEP_POP, 0, 0, -1, 1, 'h02, (i >= 3) ? 1 : 0, 1, 2, 0, -1);
        end
        add_step(STEP_POP, 0, 0, -1, 1, 'h02, 0, 1, 3, 0, -1);
        // Flags clear one cycle after sampling stops
        add_step(STEP_WRITE, acq_pkg::ADDR_ACQ_CTRL, 'h0c, -1, 0, 'h00, 0, -1, -1, 0, -1);
        add_step(STEP_IDLE, 0, 0, -1, 0, 'h00, 0, 0, 0, 0, -1);
        // Temperature one-shot, watermark 1 so any stored word shows on data_rdy
        add_step(STEP_WRITE, acq_pkg::ADDR_ACQ_CTRL, 'h04, -1, 0, 'h00, 0, 0, 0, 0, 0);
        add_step(STEP_WRITE, acq_pkg::ADDR_AFE_CTRL, 'h08, -1, 0, 'h00, 0, 0, 0, 0, 0);
        add_step(STEP_IDLE, 0, 0, -1, 1, 'h00, 0, 0, 0, 0, 0);
        add_step(STEP_DONE, 0, 0, -1, 1, 'h00, 0, 0, 0, 0, 0);
        add_step(STEP_DONE, 0, 0, -1, 0, 'h00, 0, 0, 0, 0, 1);
        add_step(STEP_IDLE, 0, 0, -1, 0, 'h00, 0, 0, 0, 0, 1);
    endtask

    // ------------------------------------------------------------
    // Drive and check
    // ------------------------------------------------------------

    task automatic check_value(input string what, input int got, input int expected);
        if (expected >= 0) begin
            checks++;
            assert (got == expected)
            else begin
                errors++;
                $display("MISMATCH at %0t: row %0d %s is 0x%0h, expected 0x%0h",
                         $time, row_idx, what, got, expected);
            end
        end
    endtask

    task automatic drive_idle();
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        result    = '0;
        done      = 1'b0;
        fifo_pop  = 1'b0;
    endtask

    task automatic apply_step(input int idx);
        step_t                        s;
        logic [acq_pkg::RESULT_W-1:0] rnd;
        s       = steps[idx];
        row_idx = idx;
        @(negedge SAMPLE_CLK);
        // Head word is stable here, compare it before it leaves
        if (s.kind == STEP_POP && model_data.size() > 0) begin
            check_value("popped word", fifo_rd_data, model_data.pop_front());
            check_value("popped channel", fifo_rd_chan, model_chan.pop_front());
        end
        drive_idle();
        case (s.kind)
            STEP_WRITE: begin
                reg_wr    = 1'b1;
                reg_addr  = acq_pkg::REG_ADDR_W'(s.addr);
                reg_wdata = acq_pkg::REG_DATA_W'(s.data);
            end
            STEP_DONE: begin
                rnd         = acq_pkg::RESULT_W'($random(seed));
                result      = rnd;
                done        = 1'b1;
                last_result = rnd;
                // Full FIFO drops the word
                if (s.chan >= 0 && model_data.size() < acq_pkg::FIFO_DEPTH) begin
                    model_data.push_back(rnd);
                    model_chan.push_back(acq_pkg::CHAN_IDX_W'(s.chan));
                end
            end
            STEP_POP: fifo_pop = 1'b1;
            default: ;
        endcase
        @(posedge SAMPLE_CLK);
        #1;
        check_value("narst", narst, s.exp_narst);
        check_value("atmchsel", atmchsel, s.exp_sel);
        check_value("data_rdy", data_rdy, s.exp_rdy);
        check_value("irq", irq, s.exp_irq);
        check_value("overflow/underflow", {fifo_overflow, fifo_underflow}, s.exp_flags);
        check_value("last_word", last_word, s.exp_last);
        check_value("temp_valid", temp_valid, s.exp_tv);
        if (s.exp_tv == 1) check_value("tempval", tempval, last_result);
    endtask

    initial begin
        drive_idle();
        checks      = 0;
        errors      = 0;
        last_result = '0;
        build_table();
        wait (nrst_sync === 1'b1);
        for (int i = 0; i < steps.size(); i++) begin
            apply_step(i);
        end
        @(negedge SAMPLE_CLK);
        drive_idle();
        errors += dut0.sva0.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut0.sva0.fail_count);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run limit scales with the table length
    initial begin
        cycles = 0;
        do begin
            @(posedge SAMPLE_CLK);
            cycles++;
        end while (cycles < 4 * steps.size() + 50);
        $display("Timeout: test did not complete within %0d clock cycles", cycles);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: acq_top.f
common/acq_pkg.sv
hdl/acq_config_regs.sv
hdl/channel_sequencer.sv
sample_fifo/sample_fifo.sv
hdl/temp_monitor.sv
hdl/acq_top.sv
tests/acq_top_sva.sv
tests/tb_clock_gen.sv
tests/acq_top_tb.sv
